//--- build.f
rtl/arcade_cfg_pkg.sv
rtl/arcade_io_pkg.sv
rtl/clock_enables.sv
rtl/input_merge.sv
rtl/player_orient.sv
rtl/button_pack.sv
rtl/audio_dac.sv
rtl/arcade_io_top.sv
tb/arcade_io_sva.sv
tb/arcade_io_tb.sv

//--- Bender.yml
package:
  name: arcade_io

sources:
  - rtl/arcade_cfg_pkg.sv
  - rtl/arcade_io_pkg.sv
  - rtl/clock_enables.sv
  - rtl/input_merge.sv
  - rtl/player_orient.sv
  - rtl/button_pack.sv
  - rtl/audio_dac.sv
  - rtl/arcade_io_top.sv
  - target: test
    files:
      - tb/arcade_io_sva.sv
      - tb/arcade_io_tb.sv

//--- tb/arcade_io_tb.sv
module arcade_io_tb
	import arcade_cfg_pkg::*;
	import arcade_io_pkg::*;
();

	typedef struct packed {
		logic [kbjoy_width-1:0]  kbjoy;
		joy_t                    joy0;
		joy_t                    joy1;
		logic [status_width-1:0] status;
		logic [1:0]              buttons;
		logic [audio_width-1:0]  sample;
	} stim_t;

	logic                    clk_sys = 1'b0;
	logic                    rst_n;
	logic [kbjoy_width-1:0]  kbjoy;
	joy_t                    joystick_0;
	joy_t                    joystick_1;
	logic [status_width-1:0] status;
	logic [1:0]              buttons;
	logic [audio_width-1:0]  audio;
	clk_en_t                 clk_en;
	core_buttons_t           core_buttons;
	logic                    core_reset;
	logic                    audio_l;
	logic                    audio_r;

	integer  seed = 32'h52c3_8533;
	stim_t   cur;
	stim_t   hist[$];
	int      edge_count;

	always #5 clk_sys = ~clk_sys;

	arcade_io_top UUT (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.kbjoy        (kbjoy),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.status       (status),
		.buttons      (buttons),
		.audio        (audio),
		.clk_en       (clk_en),
		.core_buttons (core_buttons),
		.core_reset   (core_reset),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// ====================
	// Compare tasks
	// ====================

	task automatic check_buttons(input core_buttons_t got, input core_buttons_t exp);
		if (got !== exp)
			abort_run($sformatf("error at time %0t: core_buttons %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_reset(input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error at time %0t: core_reset %b, expected %b",
				$time, got, exp));
	endtask

	task automatic check_enables(input clk_en_t got, input clk_en_t exp);
		if (got !== exp)
			abort_run($sformatf("error at time %0t: clk_en %b, expected %b",
				$time, got, exp));
	endtask

	task automatic check_audio(input int got, input int exp, input string what);
		if (got != exp)
			abort_run($sformatf("error at time %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// ====================
	// Reference model
	// ====================

	// Active-low vector with start, fire, bomb, left, right, up and down from the MSB down
	function automatic logic [6:0] model_vector(joy_t j, logic [kbjoy_width-1:0] kb,
			logic rot, logic start);
		logic u;
		logic d;
		logic l;
		logic r;
		u = j.up | kb[4];
		d = j.down | kb[5];
		l = j.left | kb[6];
		r = j.right | kb[7];
		if (rot)
			return ~{start, j.fire | kb[0], kb[8], d, u, l, r};
		return ~{start, j.fire | kb[0], kb[8], l, r, u, d};
	endfunction

	// Directions pass three registers while coin and service pass only two
	function automatic core_buttons_t model_buttons(stim_t late, stim_t early);
		core_buttons_t b;
		b.button_in1 = model_vector(late.joy0, late.kbjoy, late.status[2], late.kbjoy[1]);
		b.button_in2 = model_vector(late.joy1, late.kbjoy, late.status[2], late.kbjoy[2]);
		b.coin_n     = ~early.kbjoy[3];
		b.service_n  = ~early.kbjoy[9];
		return b;
	endfunction

	function automatic clk_en_t model_enables(int n);
		clk_en_t e;
		e.ce_12   = (n % 2) == 1;
		e.ce_6p   = (n % 4) == 1;
		e.ce_6n   = (n % 4) == 3;
		e.ce_1p79 = (n % 14) == 13;
		return e;
	endfunction

	// Orientation mode 0 keeps the cabinet upright, 1 keeps it rotated and 2 picks it at random
	task automatic random_stim(input int rot_mode, output stim_t s);
		logic [31:0] rnd;
		rnd = $random(seed);
		s.kbjoy = rnd[kbjoy_width-1:0];
		rnd = $random(seed);
		s.joy0 = rnd[7:0];
		s.joy1 = rnd[15:8];
		s.buttons = rnd[17:16];
		s.status = $random(seed);
		s.sample = cur.sample;
		if (rot_mode == 0)
			s.status[2] = 1'b0;
		else if (rot_mode == 1)
			s.status[2] = 1'b1;
	endtask

	// One clock cycle that records what the DUT samples, drives the next inputs and then checks
	task automatic step(input stim_t s);
		logic exp_reset;
		@(posedge clk_sys);
		hist.push_front(cur);
		void'(hist.pop_back());
		kbjoy      <= s.kbjoy;
		joystick_0 <= s.joy0;
		joystick_1 <= s.joy1;
		status     <= s.status;
		buttons    <= s.buttons;
		audio      <= s.sample;
		cur = s;
		@(negedge clk_sys);
		check_enables(clk_en, model_enables(edge_count));
		check_buttons(core_buttons, model_buttons(hist[2], hist[1]));
		exp_reset = hist[0].status[0] | hist[0].status[6] | hist[0].buttons[1];
		check_reset(core_reset, exp_reset);
		edge_count++;
	endtask

	task automatic wait_sound_strobe();
		stim_t s;
		int    waited;
		waited = 0;
		while (clk_en.ce_1p79 !== 1'b1) begin
			if (waited == 20) begin
				abort_run("timeout: the sound clock enable never strobed");
			end else begin
				random_stim(2, s);
				step(s);
				waited++;
			end
		end
	endtask

	// Pulse count over one full accumulator period must equal the sample on both channels
	task automatic run_audio(input logic [audio_width-1:0] smp);
		stim_t s;
		int    ones_l;
		int    ones_r;
		random_stim(2, s);
		s.sample = smp;
		step(s);
		ones_l = 0;
		ones_r = 0;
		for (int i = 0; i < 1024; i++) begin
			random_stim(2, s);
			step(s);
			ones_l += audio_l;
			ones_r += audio_r;
		end
		check_audio(ones_l, int'(smp), "audio_l ones over 1024 cycles");
		check_audio(ones_r, int'(smp), "audio_r ones over 1024 cycles");
	endtask

	initial begin : watchdog
		for (int c = 0; c < 20000; c++)
			@(posedge clk_sys);
		abort_run("timeout: the run did not finish within 20000 cycles");
	end

	initial begin
		stim_t       s;
		logic [31:0] rnd;
		rst_n      = 1'b0;
		kbjoy      = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		status     = '0;
		buttons    = '0;
		audio      = '0;
		cur        = '0;
		edge_count = 0;
		repeat (3) hist.push_back('0);
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check_buttons(core_buttons, '1);
		check_reset(core_reset, 1'b0);
		check_enables(clk_en, '0);

		// Upright, then rotated, then orientation and reset sources toggling freely
		repeat (200) begin
			random_stim(0, s);
			step(s);
		end
		repeat (200) begin
			random_stim(1, s);
			step(s);
		end
		repeat (200) begin
			random_stim(2, s);
			step(s);
		end

		wait_sound_strobe();
		run_audio(10'd0);
		run_audio(10'd1023);
		repeat (4) begin
			rnd = $random(seed);
			run_audio(rnd[audio_width-1:0]);
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- tb/arcade_io_sva.sv
module arcade_io_sva
	import arcade_io_pkg::*;
(
	input logic          clk_sys,
	input logic          rst_n,
	input clk_en_t       clk_en,
	input core_buttons_t core_buttons,
	input logic          core_reset,
	input logic          audio_l
);

	// The two 6 MHz style phases never overlap
	a_ce6_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(clk_en.ce_6p && clk_en.ce_6n)) else $error("ce_6p and ce_6n high together");

	a_ce6p_in_ce12: assert property (@(posedge clk_sys) disable iff (!rst_n)
		clk_en.ce_6p |-> clk_en.ce_12) else $error("ce_6p without ce_12");

	a_ce6n_in_ce12: assert property (@(posedge clk_sys) disable iff (!rst_n)
		clk_en.ce_6n |-> clk_en.ce_12) else $error("ce_6n without ce_12");

	// Every output is inactive right after a reset cycle
	a_reset_state: assert property (@(posedge clk_sys)
		!rst_n |=> (core_buttons == '1 && !core_reset && clk_en == '0 && !audio_l))
		else $error("outputs not inactive after reset");

endmodule

bind arcade_io_top arcade_io_sva u_arcade_io_sva (
	.clk_sys      (clk_sys),
	.rst_n        (rst_n),
	.clk_en       (clk_en),
	.core_buttons (core_buttons),
	.core_reset   (core_reset),
	.audio_l      (audio_l)
);

//--- rtl/arcade_io_top.sv
module arcade_io_top
	import arcade_cfg_pkg::*;
	import arcade_io_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic [kbjoy_width-1:0]  kbjoy,
	input  joy_t                    joystick_0,
	input  joy_t                    joystick_1,
	input  logic [status_width-1:0] status,
	input  logic [1:0]              buttons,
	input  logic [audio_width-1:0]  audio,
	output clk_en_t                 clk_en,
	output core_buttons_t           core_buttons,
	output logic                    core_reset,
	output logic                    audio_l,
	output logic                    audio_r
);

	player_raw_t  [num_players-1:0] players_raw;
	player_ctrl_t [num_players-1:0] players_ctrl;
	cabinet_t                       cabinet;

	clock_enables u_clock_enables (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.clk_en  (clk_en)
	);

	// ====================
	// Control path
	// ====================

	input_merge u_input_merge (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.kbjoy      (kbjoy),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.players    (players_raw),
		.cabinet    (cabinet)
	);

	// One orientation stage per player, all following the menu option in status[2]
	for (genvar p = 0; p < num_players; p++) begin : g_player
		player_orient u_player_orient (
			.clk_sys (clk_sys),
			.rst_n   (rst_n),
			.rotate  (status[2]),
			.raw     (players_raw[p]),
			.ctrl    (players_ctrl[p])
		);
	end

	button_pack u_button_pack (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.ctrl         (players_ctrl),
		.cabinet      (cabinet),
		.status       (status),
		.buttons      (buttons),
		.core_buttons (core_buttons),
		.core_reset   (core_reset)
	);

	// ====================
	// Audio
	// ====================

	audio_dac u_audio_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (audio),
		.dac_out (audio_l)
	);

	// Mono core, both channels carry the same bit stream
	assign audio_r = audio_l;

endmodule

//--- rtl/audio_dac.sv
module audio_dac
	import arcade_cfg_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic [audio_width-1:0] sample,
	output logic                   dac_out
);

	logic [audio_width-1:0] acc;
	logic [audio_width:0]   sum;

	// The carry out of the accumulator is the pulse density output
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[audio_width-1:0];
			dac_out <= sum[audio_width];
		end
	end

endmodule

//--- rtl/button_pack.sv
module button_pack
	import arcade_cfg_pkg::*;
	import arcade_io_pkg::*;
(
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  player_ctrl_t [num_players-1:0] ctrl,
	input  cabinet_t                       cabinet,
	input  logic         [status_width-1:0] status,
	input  logic         [1:0]             buttons,
	output core_buttons_t                  core_buttons,
	output logic                           core_reset
);

	// Core button order from MSB is start, fire, bomb, left, right, up, down
	function automatic logic [6:0] pack_active_low(player_ctrl_t c);
		return ~{c.start, c.fire, c.bomb, c.left, c.right, c.up, c.down};
	endfunction

	core_buttons_t buttons_d;
	logic          reset_req;

	assign buttons_d.button_in1 = pack_active_low(ctrl[0]);
	assign buttons_d.button_in2 = pack_active_low(ctrl[1]);
	assign buttons_d.coin_n     = ~cabinet.coin;
	assign buttons_d.service_n  = ~cabinet.service;

	// Reset from the menu, the reset toggle or the board button
	assign reset_req = status[0] | status[6] | buttons[1];

	// ====================
	// Output registers
	// ====================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			core_buttons <= '1;
			core_reset   <= 1'b0;
		end else begin
			core_buttons <= buttons_d;
			core_reset   <= reset_req;
		end
	end

endmodule

//--- rtl/player_orient.sv
module player_orient
	import arcade_io_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  logic         rotate,
	input  player_raw_t  raw,
	output player_ctrl_t ctrl
);

	// Orientation level delayed one cycle so it lines up with the merged controls
	logic         rotate_q;
	player_ctrl_t ctrl_d;

	always_comb begin
		if (rotate_q) begin
			// Rotated cabinet, the stick is turned a quarter turn
			ctrl_d.up    = raw.stick.left;
			ctrl_d.down  = raw.stick.right;
			ctrl_d.left  = raw.stick.down;
			ctrl_d.right = raw.stick.up;
		end else begin
			ctrl_d.up    = raw.stick.up;
			ctrl_d.down  = raw.stick.down;
			ctrl_d.left  = raw.stick.left;
			ctrl_d.right = raw.stick.right;
		end
		ctrl_d.fire  = raw.stick.fire;
		ctrl_d.bomb  = raw.bomb;
		ctrl_d.start = raw.start;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rotate_q <= 1'b0;
			ctrl     <= '0;
		end else begin
			rotate_q <= rotate;
			ctrl     <= ctrl_d;
		end
	end

endmodule

//--- rtl/input_merge.sv
module input_merge
	import arcade_cfg_pkg::*;
	import arcade_io_pkg::*;
(
	input  logic                               clk_sys,
	input  logic                               rst_n,
	input  logic        [kbjoy_width-1:0]      kbjoy,
	input  joy_t                               joystick_0,
	input  joy_t                               joystick_1,
	output player_raw_t [num_players-1:0]      players,
	output cabinet_t                           cabinet
);

	joy_t                    kb_stick;
	joy_t [num_players-1:0]  sticks;
	logic [num_players-1:0]  kb_start;
	player_raw_t [num_players-1:0] players_d;

	// Keyboard cursor keys and fire, rearranged into the joystick layout
	assign kb_stick = '{
		spare: 3'b000,
		fire:  kbjoy[0],
		up:    kbjoy[4],
		down:  kbjoy[5],
		left:  kbjoy[6],
		right: kbjoy[7]
	};

	assign sticks   = {joystick_1, joystick_0};
	assign kb_start = {kbjoy[2], kbjoy[1]};

	// Each player sees its own joystick plus the shared keyboard
	always_comb begin
		for (int p = 0; p < num_players; p++) begin
			players_d[p].stick = sticks[p] | kb_stick;
			players_d[p].start = kb_start[p];
			players_d[p].bomb  = kbjoy[8];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			players <= '0;
			cabinet <= '0;
		end else begin
			players         <= players_d;
			cabinet.coin    <= kbjoy[3];
			cabinet.service <= kbjoy[9];
		end
	end

endmodule

//--- rtl/clock_enables.sv
module clock_enables
	import arcade_cfg_pkg::*;
	import arcade_io_pkg::*;
(
	input  logic    clk_sys,
	input  logic    rst_n,
	output clk_en_t clk_en
);

	logic [ce_phase_width-1:0] phase;
	logic [snd_div_width-1:0]  snd_div;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase   <= '0;
			snd_div <= snd_div_width'(snd_div_reload);
			clk_en  <= '0;
		end else begin
			phase <= phase + 1'b1;

			// 12 MHz style enable on every odd phase
			clk_en.ce_12 <= phase[0];

			// The two 6 MHz style enables sit half a period apart
			clk_en.ce_6p <= phase[0] & ~phase[1];
			clk_en.ce_6n <= phase[0] & phase[1];

			// Sound enable from the divide-by-14 down-counter
			if (snd_div == '0) begin
				snd_div        <= snd_div_width'(snd_div_reload);
				clk_en.ce_1p79 <= 1'b1;
			end else begin
				snd_div        <= snd_div - 1'b1;
				clk_en.ce_1p79 <= 1'b0;
			end
		end
	end

endmodule

//--- rtl/arcade_io_pkg.sv
package arcade_io_pkg;

	// Clock enable strobes handed to the game core
	typedef struct packed {
		logic ce_12;
		logic ce_6p;
		logic ce_6n;
		logic ce_1p79;
	} clk_en_t;

	// Joystick word as delivered by the IO controller, right is bit 0
	typedef struct packed {
		logic [2:0] spare;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// One player's merged controls before the cabinet orientation is applied
	typedef struct packed {
		joy_t stick;
		logic start;
		logic bomb;
	} player_raw_t;

	// One player's controls after orientation, all active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic start;
	} player_ctrl_t;

	// Inputs shared by the whole cabinet
	typedef struct packed {
		logic coin;
		logic service;
	} cabinet_t;

	// Active-low inputs of the game core
	typedef struct packed {
		logic [6:0] button_in1;
		logic [6:0] button_in2;
		logic       coin_n;
		logic       service_n;
	} core_buttons_t;

endpackage

//--- rtl/arcade_cfg_pkg.sv
package arcade_cfg_pkg;

	// ====================
	// Clock enable division
	// ====================

	// Phase counter for the 12 MHz and 6 MHz style enables
	localparam int unsigned ce_phase_width = 2;

	// Sound enable divider, one strobe every snd_div_reload + 1 cycles
	localparam int unsigned snd_div_width  = 4;
	localparam int unsigned snd_div_reload = 13;

	// ====================
	// Datapath widths
	// ====================

	localparam int unsigned audio_width  = 10;
	localparam int unsigned kbjoy_width  = 10;
	localparam int unsigned status_width = 32;

	// Number of player control stages
	localparam int unsigned num_players = 2;

endpackage
